//--- src.f
common/obi_pkg.sv
common/lsu_pkg.sv
lsu/lsu_ctrl.sv
lsu/lsu_write_buffer.sv
lsu/lsu_bus_monitor.sv
design/lsu_top.sv
test/tb_mem_model.sv
test/tb_lsu.sv

//--- Makefile
TB_TOP := tb_lsu

.PHONY: sim lint clean

sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -x "all tests passed" > /dev/null

obj_dir/V$(TB_TOP): src.f common/*.sv lsu/*.sv design/*.sv test/*.sv
	verilator --binary --timing -f src.f --top-module $(TB_TOP)

lint:
	verilator --lint-only --timing -f src.f --top-module lsu_top

clean:
	rm -rf obj_dir

//--- test/tb_lsu.sv
////////////////////////////////////////
// LSU testbench top
// Clock, reset, directed and random core
// accesses against a byte-wide shadow of
// memory, and the spurious rvalid check
////////////////////////////////////////

`timescale 1ns/1ps

module tb_lsu;
  import obi_pkg::*;
  import lsu_pkg::*;

  localparam int NUM_RANDOM = 400;
  localparam int TIMEOUT    = 200;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       req_valid;
  lsu_req_t   req;
  logic       ready;
  logic       rsp_valid;
  lsu_rsp_t   rsp;
  logic       busy;
  obi_req_t   obi_req;
  obi_rsp_t   obi_rsp;
  mon_err_t   mon_err;
  mon_err_t   exp_err;
  lsu_req_t   rnd_req;
  logic [7:0] shadow [0:1023];
  int         seed;
  int         req_count;
  int         rsp_count = 0;
  int         sel;
  int         waited;

  always #20 clk = ~clk;

  lsu_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .ready_o     (ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .busy_o      (busy),
    .obi_req_o   (obi_req),
    .obi_rsp_i   (obi_rsp),
    .mon_err_o   (mon_err)
  );

  tb_mem_model i_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .obi_req_i (obi_req),
    .obi_rsp_o (obi_rsp)
  );

  // Each response pulse is counted once and a stretched pulse twice
  always @(posedge clk) begin
    if (rsp_valid) begin
      rsp_count = rsp_count + 1;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Initial memory bytes as filled by the memory model
  function automatic logic [7:0] fill_byte(input logic [9:0] baddr);
    logic [7:0] w;
    w = baddr[9:2];
    case (baddr[1:0])
      2'd0:    return w;
      2'd1:    return w + 8'h3c;
      2'd2:    return w ^ 8'h5a;
      default: return ~w;
    endcase
  endfunction

  function automatic logic in_window(input logic [9:0] baddr);
    return baddr[9:6] == 4'hc;
  endfunction

  // Bytes are handled one by one so a split needs no special case
  task automatic model_access(input lsu_req_t r, output lsu_rsp_t exp);
    int         nbytes;
    logic [9:0] b;
    nbytes = (r.size == SIZE_BYTE) ? 1 : ((r.size == SIZE_HALF) ? 2 : 4);
    exp    = '0;
    for (int i = 0; i < nbytes; i++) begin
      b = r.addr[9:0] + 10'(i);
      if (in_window(b)) begin
        exp.err = 1'b1;
      end else if (r.we) begin
        shadow[b] = r.wdata[8*i +: 8];
      end
      // Loads see the memory even in the error window and stores return zero
      if (!r.we) begin
        exp.rdata[8*i +: 8] = shadow[b];
      end
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_rsp(input lsu_rsp_t got, input lsu_rsp_t exp);
    if (got.rdata !== exp.rdata) begin
      $display("Fail rsp_o.rdata got %h expected %h", got.rdata, exp.rdata);
      abort_run();
    end
    if (got.err !== exp.err) begin
      $display("Fail rsp_o.err got %h expected %h", got.err, exp.err);
      abort_run();
    end
  endtask

  task automatic check_err(input mon_err_t got, input mon_err_t exp);
    if (got !== exp) begin
      $display("Fail mon_err_o got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_prot(input obi_prot_t got, input obi_prot_t exp);
    if (got !== exp) begin
      $display("Fail obi_req_o.prot got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Every accepted transfer carries the prot of the core access it belongs to
  always @(posedge clk) begin
    if (obi_req.req && obi_rsp.gnt) begin
      check_prot(obi_req.prot, req.prot);
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic lsu_req_t make_req(input obi_addr_t addr, input logic we,
                                        input lsu_size_e size, input obi_data_t wdata);
    lsu_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.size  = size;
    r.wdata = wdata;
    r.prot  = 3'b010;
    return r;
  endfunction

  // One access from request pulse to response with all sampling 1 ns after the edge
  task automatic do_access(input lsu_req_t r);
    lsu_rsp_t exp;
    int       cnt;
    cnt = 0;
    while (!ready) begin
      @(posedge clk);
      #1;
      cnt = cnt + 1;
      if (cnt > TIMEOUT) begin
        $display("ready_o stayed low while waiting to issue a request");
        abort_run();
      end
    end
    model_access(r, exp);
    req       = r;
    req_valid = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    cnt       = 0;
    while (!rsp_valid) begin
      @(posedge clk);
      #1;
      cnt = cnt + 1;
      if (cnt > TIMEOUT) begin
        $display("no response arrived for a request at address %h", r.addr);
        abort_run();
      end
    end
    req_count = req_count + 1;
    check_rsp(rsp, exp);
    check_bit("ready_o", ready, 1'b1);
    check_bit("busy_o", busy, 1'b0);
    check_err(mon_err, '0);
  endtask

  initial begin
    seed      = 16619;
    req_count = 0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int k = 0; k < 1024; k++) begin
      shadow[k] = fill_byte(10'(k));
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("ready_o", ready, 1'b1);
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("obi_req_o.req", obi_req.req, 1'b0);
    check_err(mon_err, '0);

    // Aligned store followed by loads of every size from the same word
    do_access(make_req(32'h10, 1'b1, SIZE_WORD, 32'hcafe_f00d));
    do_access(make_req(32'h11, 1'b0, SIZE_BYTE, '0));
    do_access(make_req(32'h12, 1'b0, SIZE_HALF, '0));
    do_access(make_req(32'h10, 1'b0, SIZE_WORD, '0));
    // Word-crossing store and loads
    do_access(make_req(32'h1e, 1'b1, SIZE_WORD, 32'h1234_5678));
    do_access(make_req(32'h1f, 1'b0, SIZE_HALF, '0));
    do_access(make_req(32'h1d, 1'b0, SIZE_WORD, '0));
    // Error window hit by part 0 and then by part 1
    do_access(make_req(32'h33e, 1'b0, SIZE_WORD, '0));
    do_access(make_req(32'h2fe, 1'b1, SIZE_WORD, 32'h0bad_beef));
    do_access(make_req(32'h2fc, 1'b0, SIZE_WORD, '0));

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd_req.addr  = {22'h0, 10'($random(seed))};
      rnd_req.we    = 1'($random(seed));
      sel           = int'($unsigned($random(seed)) % 3);
      rnd_req.size  = (sel == 0) ? SIZE_BYTE : ((sel == 1) ? SIZE_HALF : SIZE_WORD);
      rnd_req.wdata = $random(seed);
      rnd_req.prot  = 3'($random(seed));
      do_access(rnd_req);
    end

    // The unit is idle here so any rvalid is unexpected
    i_mem.inject_spurious_rvalid();
    waited = 0;
    while (!mon_err.spurious_rvalid) begin
      @(posedge clk);
      #1;
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        $display("the monitor did not flag the injected spurious rvalid");
        abort_run();
      end
    end
    exp_err                 = '0;
    exp_err.spurious_rvalid = 1'b1;
    check_err(mon_err, exp_err);
    @(posedge clk);
    #1;
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    if (rsp_count != req_count) begin
      $display("saw %0d responses for %0d requests", rsp_count, req_count);
      abort_run();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- test/tb_mem_model.sv
////////////////////////////////////////
// Bus memory model for the LSU testbench
// 256 words behind a simplified OBI port
// with random grant stalls, random and
// in-order response latency, an error
// window and one-shot spurious rvalid
////////////////////////////////////////

`timescale 1ns/1ps

module tb_mem_model (
  input  logic              clk,
  input  logic              rst_n,
  input  obi_pkg::obi_req_t obi_req_i,
  output obi_pkg::obi_rsp_t obi_rsp_o
);
  import obi_pkg::*;

  // One queued response, due is the cycle whose rising edge samples it
  typedef struct packed {
    int        due;
    obi_data_t data;
    logic      err;
  } rsp_entry_t;

  obi_data_t  mem [0:255];
  rsp_entry_t rsp_q [$];
  rsp_entry_t entry;
  int         seed;
  int         cyc;
  int         last_due;
  int         spur_asked = 0;
  int         spur_done;
  logic [7:0] idx;

  // Words 0x300 to 0x33f of the byte space answer with err
  function automatic logic in_err_window(input obi_addr_t addr);
    return addr[9:6] == 4'hc;
  endfunction

  // Asks for one rvalid pulse that belongs to no transfer
  task inject_spurious_rvalid();
    spur_asked = spur_asked + 1;
  endtask

  initial begin
    seed      = 16619;
    cyc       = 0;
    last_due  = 0;
    spur_done = 0;
    obi_rsp_o = '0;
    // Every byte depends on the full word address
    for (int i = 0; i < 256; i++) begin
      idx    = 8'(i);
      mem[i] = {~idx, idx ^ 8'h5a, idx + 8'h3c, idx};
    end
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      // A transfer is accepted on this edge when req and gnt are both high
      if (obi_req_i.req && obi_rsp_o.gnt) begin
        idx        = obi_req_i.addr[9:2];
        entry.err  = in_err_window(obi_req_i.addr);
        entry.data = '0;
        if (obi_req_i.we) begin
          // Writes into the error window are dropped
          for (int b = 0; b < 4; b++) begin
            if (obi_req_i.be[b] && !entry.err) begin
              mem[idx][8*b +: 8] = obi_req_i.wdata[8*b +: 8];
            end
          end
        end else begin
          entry.data = mem[idx];
        end
        // Latency of 1 to 4 cycles, pushed back to keep one response per cycle
        entry.due = cyc + 1 + int'($unsigned($random(seed)) % 4);
        if (entry.due <= last_due) begin
          entry.due = last_due + 1;
        end
        last_due = entry.due;
        rsp_q.push_back(entry);
      end
      #1;
      obi_rsp_o.gnt    = rst_n && (($unsigned($random(seed)) % 10) < 7);
      obi_rsp_o.rvalid = 1'b0;
      obi_rsp_o.rdata  = '0;
      obi_rsp_o.err    = 1'b0;
      if ((rsp_q.size() != 0) && (rsp_q[0].due <= cyc + 1)) begin
        entry            = rsp_q.pop_front();
        obi_rsp_o.rvalid = 1'b1;
        obi_rsp_o.rdata  = entry.data;
        obi_rsp_o.err    = entry.err;
      end else if ((spur_asked != spur_done) && (rsp_q.size() == 0)) begin
        // Only sent while nothing is in flight
        obi_rsp_o.rvalid = 1'b1;
        spur_done        = spur_done + 1;
      end
    end
  end

endmodule

//--- design/lsu_top.sv
////////////////////////////////////////
// Load/store unit top level
// Controller, write buffer and bus
// monitor between core and OBI ports
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              ready_o,
  output logic              rsp_valid_o,
  output lsu_pkg::lsu_rsp_t rsp_o,
  output logic              busy_o,
  output obi_pkg::obi_req_t obi_req_o,
  input  obi_pkg::obi_rsp_t obi_rsp_i,
  output lsu_pkg::mon_err_t mon_err_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  // Controller to write buffer
  obi_req_t    ctrl_req;
  logic        wbuf_ready;
  logic        gnt_accept;
  // Monitor taps
  wbuf_state_e wbuf_state;
  logic        split_start;

  lsu_ctrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .ready_o       (ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .busy_o        (busy_o),
    .ctrl_req_o    (ctrl_req),
    .wbuf_ready_i  (wbuf_ready),
    .obi_rsp_i     (obi_rsp_i),
    .gnt_accept_i  (gnt_accept),
    .split_start_o (split_start)
  );

  lsu_write_buffer i_wbuf (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_req_i   (ctrl_req),
    .wbuf_ready_o (wbuf_ready),
    .obi_req_o    (obi_req_o),
    .obi_gnt_i    (obi_rsp_i.gnt),
    .wbuf_state_o (wbuf_state),
    .gnt_accept_o (gnt_accept)
  );

  lsu_bus_monitor i_mon (
    .clk           (clk),
    .rst_n         (rst_n),
    .obi_req_i     (obi_req_o),
    .obi_rsp_i     (obi_rsp_i),
    .wbuf_state_i  (wbuf_state),
    .split_start_i (split_start),
    .err_o         (mon_err_o)
  );

endmodule

//--- lsu/lsu_bus_monitor.sv
////////////////////////////////////////
// OBI data bus protocol monitor
// Own outstanding counter, spurious
// rvalid check and split prot check,
// reported as sticky error flags
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_bus_monitor (
  input  logic                 clk,
  input  logic                 rst_n,
  input  obi_pkg::obi_req_t    obi_req_i,
  input  obi_pkg::obi_rsp_t    obi_rsp_i,
  input  lsu_pkg::wbuf_state_e wbuf_state_i,
  input  logic                 split_start_i,
  output lsu_pkg::mon_err_t    err_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  logic      accept;
  logic      cnt_down;
  lsu_cnt_t  cnt_q, cnt_d;
  obi_prot_t prot_prev_q;
  lsu_cnt_t  split_rem_q;
  lsu_cnt_t  rem_init;
  mon_err_t  err_q, err_d;

  assign accept   = obi_req_i.req && obi_rsp_i.gnt;
  assign cnt_down = obi_rsp_i.rvalid && (cnt_q != '0);

  ////////////////////////////////////////
  // Outstanding transfers
  ////////////////////////////////////////

  // Saturates at LSU_DEPTH so a single overflow does not wrap the count
  always_comb begin
    cnt_d = cnt_q;
    if (accept && !cnt_down && (cnt_q < lsu_cnt_t'(LSU_DEPTH))) begin
      cnt_d = cnt_q + lsu_cnt_t'(1);
    end else if (!accept && cnt_down) begin
      cnt_d = cnt_q - lsu_cnt_t'(1);
    end
  end

  ////////////////////////////////////////
  // Split tracking
  ////////////////////////////////////////

  // Transfers still to be accepted up to and including part 1 of the split
  // A full buffer puts one older transfer ahead of part 0
  always_comb begin
    rem_init = lsu_cnt_t'(2);
    if (wbuf_state_i == WBUF_FULL) begin
      rem_init = rem_init + lsu_cnt_t'(1);
    end
    if (accept) begin
      rem_init = rem_init - lsu_cnt_t'(1);
    end
  end

  // Flags only ever go high
  always_comb begin
    err_d = err_q;
    if (accept && !cnt_down && (cnt_q == lsu_cnt_t'(LSU_DEPTH))) begin
      err_d.cnt_overflow = 1'b1;
    end
    if (obi_rsp_i.rvalid && (cnt_q == '0)) begin
      err_d.spurious_rvalid = 1'b1;
    end
    // Part 1 is the transfer accepted when one remains
    if ((split_rem_q == lsu_cnt_t'(1)) && accept && (obi_req_i.prot != prot_prev_q)) begin
      err_d.split_prot = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q       <= '0;
      prot_prev_q <= '0;
      split_rem_q <= '0;
      err_q       <= '0;
    end else begin
      cnt_q <= cnt_d;
      err_q <= err_d;
      if (accept) begin
        prot_prev_q <= obi_req_i.prot;
      end
      if (split_start_i && (split_rem_q == '0)) begin
        split_rem_q <= rem_init;
      end else if (accept && (split_rem_q != '0)) begin
        split_rem_q <= split_rem_q - lsu_cnt_t'(1);
      end
    end
  end

  assign err_o = err_q;

endmodule

//--- lsu/lsu_write_buffer.sv
////////////////////////////////////////
// One-entry write buffer
// Holds a transfer the bus has not yet
// granted and presents it until granted
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_write_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  obi_pkg::obi_req_t    ctrl_req_i,
  output logic                 wbuf_ready_o,
  output obi_pkg::obi_req_t    obi_req_o,
  input  logic                 obi_gnt_i,
  output lsu_pkg::wbuf_state_e wbuf_state_o,
  output logic                 gnt_accept_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  wbuf_state_e state_q, state_d;
  obi_req_t    entry_q;
  logic        capture;

  // Room for a new transfer when empty or when the entry leaves this cycle
  assign wbuf_ready_o = (state_q == WBUF_EMPTY) || obi_gnt_i;

  // An empty buffer is transparent, a full one owns the bus request
  assign obi_req_o = (state_q == WBUF_FULL) ? entry_q : ctrl_req_i;

  assign gnt_accept_o = obi_req_o.req && obi_gnt_i;

  // Store the offered transfer unless it goes straight onto the bus
  assign capture = ctrl_req_i.req && wbuf_ready_o &&
                   ((state_q == WBUF_FULL) || !obi_gnt_i);

  always_comb begin
    state_d = state_q;
    if (capture) begin
      state_d = WBUF_FULL;
    end else if (obi_gnt_i) begin
      // Entry drained with nothing behind it
      state_d = WBUF_EMPTY;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      entry_q <= ctrl_req_i;
    end
  end

  assign wbuf_state_o = state_q;

endmodule

//--- lsu/lsu_ctrl.sv
////////////////////////////////////////
// Load/store controller
// Takes one core access at a time, splits
// word-crossing accesses into two aligned
// transfers, tracks outstanding transfers
// and merges the read data of both parts
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  lsu_pkg::lsu_req_t  req_i,
  output logic               ready_o,
  output logic               rsp_valid_o,
  output lsu_pkg::lsu_rsp_t  rsp_o,
  output logic               busy_o,
  output obi_pkg::obi_req_t  ctrl_req_o,
  input  logic               wbuf_ready_i,
  input  obi_pkg::obi_rsp_t  obi_rsp_i,
  input  logic               gnt_accept_i,
  output logic               split_start_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  ctrl_state_e state_q, state_d;
  lsu_req_t    req_q;
  lsu_cnt_t    cnt_q, cnt_d;
  logic        split;
  logic        hand_over;
  logic        rsp_take;
  logic        rsp_last;
  logic        rsp_idx_q;
  obi_data_t   rd0_q;
  logic        err0_q;
  logic [7:0]  be_wide;
  logic [63:0] wdata_wide;
  logic [63:0] rdata_wide;
  logic [63:0] rdata_shift;
  obi_data_t   size_mask;
  logic        rsp_valid_q;
  lsu_rsp_t    rsp_q;

  ////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////

  // A word at offset 1..3 or a halfword at offset 3 crosses into the next word
  assign split = ((req_q.size == SIZE_WORD) && (req_q.addr[1:0] != 2'b00)) ||
                 ((req_q.size == SIZE_HALF) && (req_q.addr[1:0] == 2'b11));

  always_comb begin
    case (req_q.size)
      SIZE_BYTE: size_mask = 32'h0000_00ff;
      SIZE_HALF: size_mask = 32'h0000_ffff;
      default:   size_mask = 32'hffff_ffff;
    endcase
  end

  // Lanes and data of both words in one 8-byte window, the upper half is part 1
  assign be_wide    = {4'b0000, size_mask[24], size_mask[16], size_mask[8], size_mask[0]}
                      << req_q.addr[1:0];
  assign wdata_wide = {32'h0, req_q.wdata} << {req_q.addr[1:0], 3'b000};

  // Transfer to the write buffer, part 1 sits one word above part 0
  always_comb begin
    ctrl_req_o       = '0;
    ctrl_req_o.req   = ((state_q == CTRL_ISSUE_0) || (state_q == CTRL_ISSUE_1)) &&
                       (cnt_q < lsu_cnt_t'(LSU_DEPTH));
    ctrl_req_o.we    = req_q.we;
    ctrl_req_o.prot  = req_q.prot;
    ctrl_req_o.addr  = {req_q.addr[31:2], 2'b00};
    ctrl_req_o.be    = be_wide[3:0];
    ctrl_req_o.wdata = wdata_wide[31:0];
    if (state_q == CTRL_ISSUE_1) begin
      ctrl_req_o.addr  = {req_q.addr[31:2], 2'b00} + obi_addr_t'(4);
      ctrl_req_o.be    = be_wide[7:4];
      ctrl_req_o.wdata = wdata_wide[63:32];
    end
  end

  assign hand_over     = ctrl_req_o.req && wbuf_ready_i;
  assign split_start_o = hand_over && (state_q == CTRL_ISSUE_0) && split;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  // Responses only belong to us while an access is open
  assign rsp_take = obi_rsp_i.rvalid && (state_q != CTRL_IDLE);
  assign rsp_last = rsp_take && (!split || rsp_idx_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE:    if (req_valid_i) state_d = CTRL_ISSUE_0;
      CTRL_ISSUE_0: if (hand_over) state_d = split ? CTRL_ISSUE_1 : CTRL_WAIT;
      CTRL_ISSUE_1: if (hand_over) state_d = CTRL_WAIT;
      default:      if (rsp_last) state_d = CTRL_IDLE;
    endcase
  end

  // Outstanding count follows bus acceptance, not the buffer hand-over
  always_comb begin
    cnt_d = cnt_q;
    case ({gnt_accept_i, obi_rsp_i.rvalid && (cnt_q != '0)})
      2'b10:   cnt_d = cnt_q + lsu_cnt_t'(1);
      2'b01:   cnt_d = cnt_q - lsu_cnt_t'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  // Part 1 data sits above part 0, shifting right aligns the access to bit 0
  assign rdata_wide  = split ? {obi_rsp_i.rdata, rd0_q} : {32'h0, obi_rsp_i.rdata};
  assign rdata_shift = rdata_wide >> {req_q.addr[1:0], 3'b000};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= CTRL_IDLE;
      cnt_q       <= '0;
      rsp_idx_q   <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      rsp_valid_q <= rsp_last;
      if (state_q == CTRL_IDLE) begin
        rsp_idx_q <= 1'b0;
      end else if (rsp_take && !rsp_last) begin
        rsp_idx_q <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if ((state_q == CTRL_IDLE) && req_valid_i) begin
      req_q <= req_i;
    end
    if (rsp_take && !rsp_last) begin
      rd0_q  <= obi_rsp_i.rdata;
      err0_q <= obi_rsp_i.err;
    end
    if (rsp_last) begin
      rsp_q.rdata <= rdata_shift[31:0] & size_mask;
      rsp_q.err   <= obi_rsp_i.err | (split & err0_q);
    end
  end

  assign ready_o     = (state_q == CTRL_IDLE);
  assign busy_o      = (state_q != CTRL_IDLE) || (cnt_q != '0);
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- common/lsu_pkg.sv
////////////////////////////////////////
// Core-side types of the load/store unit
// Access size, request and response
// structs, FSM state encodings, monitor
// error flags and the outstanding depth
////////////////////////////////////////

package lsu_pkg;

  ////////////////////////////////////////
  // Limits and counters
  ////////////////////////////////////////

  // Largest number of bus transfers allowed in flight
  localparam int unsigned LSU_DEPTH = 2;

  // Wide enough to hold 0 to LSU_DEPTH
  typedef logic [1:0] lsu_cnt_t;

  ////////////////////////////////////////
  // Core interface
  ////////////////////////////////////////

  // Access width requested by the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // One load or store as issued by the core
  typedef struct packed {
    obi_pkg::obi_addr_t addr;
    logic               we;
    lsu_size_e          size;
    obi_pkg::obi_data_t wdata;
    obi_pkg::obi_prot_t prot;
  } lsu_req_t;

  // Result returned to the core, read data is zero-extended
  typedef struct packed {
    obi_pkg::obi_data_t rdata;
    logic               err;
  } lsu_rsp_t;

  ////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////

  typedef enum logic {
    WBUF_EMPTY = 1'b0,
    WBUF_FULL  = 1'b1
  } wbuf_state_e;

  typedef enum logic [1:0] {
    CTRL_IDLE    = 2'b00,
    CTRL_ISSUE_0 = 2'b01,
    CTRL_ISSUE_1 = 2'b10,
    CTRL_WAIT    = 2'b11
  } ctrl_state_e;

  // Sticky protocol error flags from the bus monitor
  typedef struct packed {
    logic cnt_overflow;
    logic spurious_rvalid;
    logic split_prot;
  } mon_err_t;

endpackage

//--- common/obi_pkg.sv
////////////////////////////////////////
// Types for the simplified OBI data bus
// Width typedefs for address, data, byte
// enables and protection code, plus the
// request and response structs
////////////////////////////////////////

package obi_pkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  // Byte address on the data bus
  typedef logic [31:0] obi_addr_t;

  // One bus data word
  typedef logic [31:0] obi_data_t;

  // One enable per byte lane of a data word
  typedef logic [3:0]  obi_be_t;

  // Protection code that travels with every request
  typedef logic [2:0]  obi_prot_t;

  ////////////////////////////////////////
  // Channel structs
  ////////////////////////////////////////

  // Address phase, driven by the manager
  // The payload must stay stable while req is high and gnt is low
  typedef struct packed {
    logic      req;
    obi_addr_t addr;
    logic      we;
    obi_be_t   be;
    obi_data_t wdata;
    obi_prot_t prot;
  } obi_req_t;

  // Grant and response phase, driven by the subordinate
  // Responses come back in order, one per rvalid pulse
  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    obi_data_t rdata;
    logic      err;
  } obi_rsp_t;

endpackage
